// File: qgate_pkg.sv
`default_nettype none

package qgate_pkg;

	typedef logic [4:0] tile_t; // Tile code 1..18
	typedef logic [8:0] prob_t; // Percent, 0..100

	// Tile layout
	localparam tile_t TILE_FIRST = 5'd1;
	localparam tile_t ROW_LEN = 5'd8;
	localparam tile_t GATE_LAST = 5'd16;
	localparam tile_t TILE_RUN = 5'd17;
	localparam tile_t TILE_CLEAR = 5'd18;

	typedef enum logic [1:0] {
		TK_GATE,
		TK_RUN,
		TK_CLEAR
	} tile_kind_t;

	typedef enum logic {
		Q_A, // Tiles 1-4 and 9-12
		Q_B
	} qubit_t;

	typedef enum logic {
		BUILDING,
		DONE
	} build_state_t;

	// Register file shape
	localparam int REG_ADDR_W = 5;
	localparam int DATA_W = 32;

	// Written once when the circuit is run
	localparam logic [REG_ADDR_W-1:0] RUN_REG = 5'd6;
	localparam logic [DATA_W-1:0] RUN_CODE = 32'd999;

	// Outcome probabilities for the first two placements
	localparam prob_t PROB_ZERO = 9'd0;
	localparam prob_t PROB_HALF = 9'd50;
	localparam prob_t PROB_FULL = 9'd100;

endpackage

`default_nettype wire

// File: cursor_nav.sv
`default_nettype none
`timescale 1ns/1ns

module cursor_nav import qgate_pkg::*; (
	input wire logic BTNC,
	input wire logic CPU_RESETN,
	input wire logic btn_r,
	input wire logic btn_l,
	input wire logic btn_u,
	input wire logic btn_d,
	output tile_t cursor
);

	localparam tile_t ROW2_FIRST = ROW_LEN + 5'd1; // Tile 9
	localparam tile_t UP_FROM_RUN = 5'd10;
	localparam tile_t UP_FROM_CLEAR = 5'd15;
	localparam tile_t ROW2_SPLIT = 5'd12; // Last tile that drops onto run

	tile_t cursor_nxt;
	logic in_row1;
	logic in_row2;

	assign in_row1 = (cursor >= TILE_FIRST) && (cursor <= ROW_LEN);
	assign in_row2 = (cursor >= ROW2_FIRST) && (cursor <= GATE_LAST);

	always_comb begin
		cursor_nxt = cursor; // Hold unless a move applies
		if (btn_r) begin
			if (cursor == ROW_LEN)
				cursor_nxt = TILE_FIRST;
			else if (cursor == GATE_LAST)
				cursor_nxt = ROW2_FIRST;
			else if (cursor == TILE_CLEAR)
				cursor_nxt = TILE_RUN;
			else
				cursor_nxt = cursor + 5'd1;
		end else if (btn_l) begin
			if (cursor == TILE_FIRST)
				cursor_nxt = ROW_LEN;
			else if (cursor == ROW2_FIRST)
				cursor_nxt = GATE_LAST;
			else if (cursor == TILE_RUN)
				cursor_nxt = TILE_CLEAR;
			else
				cursor_nxt = cursor - 5'd1;
		end else if (btn_u) begin
			if (cursor == TILE_RUN)
				cursor_nxt = UP_FROM_RUN;
			else if (cursor == TILE_CLEAR)
				cursor_nxt = UP_FROM_CLEAR;
			else if (in_row2)
				cursor_nxt = cursor - ROW_LEN;
		end else if (btn_d) begin
			if (in_row2)
				cursor_nxt = (cursor <= ROW2_SPLIT) ? TILE_RUN : TILE_CLEAR;
			else if (in_row1)
				cursor_nxt = cursor + ROW_LEN;
		end
	end

	always_ff @(posedge BTNC) begin
		if (!CPU_RESETN)
			cursor <= TILE_FIRST;
		else
			cursor <= cursor_nxt;
	end

	a_cursor_range: assert property (@(posedge BTNC) disable iff (!CPU_RESETN)
		cursor inside {[TILE_FIRST:TILE_CLEAR]})
		else $error("cursor left the tile range");

endmodule

`default_nettype wire

// File: circuit_recorder.sv
`default_nettype none
`timescale 1ns/1ns

module circuit_recorder import qgate_pkg::*; #(
	parameter int NUM_SLOTS = 5
) (
	input wire logic BTNC,
	input wire logic CPU_RESETN,
	input wire logic btn_select,
	input wire tile_t cursor,
	output logic [3:0] gate_count,
	output prob_t prob_a,
	output prob_t prob_b,
	output logic done,
	output logic bld_we,
	output logic [REG_ADDR_W-1:0] bld_waddr,
	output logic [DATA_W-1:0] bld_wdata
);

	localparam int SLOT_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
	localparam logic [3:0] SLOT_MAX = 4'(NUM_SLOTS);

	tile_t slots [NUM_SLOTS];
	build_state_t state;
	tile_kind_t tile_kind;
	qubit_t qubit;
	prob_t prob_sel;
	tile_t tile_ofs;
	logic [SLOT_W-1:0] wr_slot; // Slot behind the pending write
	logic wr_run; // Pending write is the run code

	assign tile_ofs = cursor - TILE_FIRST; // Zero-based tile index

	// Tile decode
	always_comb begin
		if (cursor == TILE_RUN)
			tile_kind = TK_RUN;
		else if (cursor == TILE_CLEAR)
			tile_kind = TK_CLEAR;
		else
			tile_kind = TK_GATE;
		qubit = tile_ofs[2] ? Q_B : Q_A; // Columns 5-8 act on b
		case (tile_ofs[1:0])
			2'd2: prob_sel = PROB_ZERO;
			2'd3: prob_sel = PROB_HALF;
			default: prob_sel = PROB_FULL;
		endcase
	end

	always_ff @(posedge BTNC) begin
		if (!CPU_RESETN) begin
			state <= BUILDING;
			gate_count <= '0;
			prob_a <= PROB_ZERO;
			prob_b <= PROB_ZERO;
			bld_we <= 1'b0;
			wr_run <= 1'b0;
			wr_slot <= '0;
			for (int i = 0; i < NUM_SLOTS; i++)
				slots[i] <= '0;
		end else begin
			bld_we <= 1'b0; // One-cycle write pulse
			if (btn_select) begin
				case (tile_kind)
					TK_CLEAR: begin
						gate_count <= '0;
						prob_a <= PROB_ZERO;
						prob_b <= PROB_ZERO;
						for (int i = 0; i < NUM_SLOTS; i++)
							slots[i] <= '0;
					end
					TK_RUN: begin
						if (state == BUILDING) begin
							state <= DONE;
							bld_we <= 1'b1;
							wr_run <= 1'b1;
						end
					end
					default: begin
						// Full circuit or finished run drops the select
						if (state == BUILDING && gate_count < SLOT_MAX) begin
							slots[gate_count[SLOT_W-1:0]] <= cursor;
							wr_slot <= gate_count[SLOT_W-1:0];
							wr_run <= 1'b0;
							bld_we <= 1'b1;
							gate_count <= gate_count + 4'd1;
							if (gate_count < 4'd2) begin
								if (qubit == Q_A)
									prob_a <= prob_sel;
								else
									prob_b <= prob_sel;
							end
						end
					end
				endcase
			end
		end
	end

	assign done = (state == DONE);

	// Write data comes back out of slot storage
	assign bld_waddr = wr_run ? RUN_REG : REG_ADDR_W'(wr_slot);
	assign bld_wdata = wr_run ? RUN_CODE : DATA_W'(slots[wr_slot]);

	a_count_bound: assert property (@(posedge BTNC) disable iff (!CPU_RESETN)
		gate_count <= SLOT_MAX)
		else $error("gate count above slot count");

endmodule

`default_nettype wire

// File: regfile_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module regfile_arbiter import qgate_pkg::*; (
	input wire logic BTNC,
	input wire logic CPU_RESETN,
	input wire logic bld_we,
	input wire logic [REG_ADDR_W-1:0] bld_waddr,
	input wire logic [DATA_W-1:0] bld_wdata,
	input wire logic cpu_we,
	input wire logic [REG_ADDR_W-1:0] cpu_waddr,
	input wire logic [DATA_W-1:0] cpu_wdata,
	input wire logic done,
	output logic rf_we,
	output logic [REG_ADDR_W-1:0] rf_waddr,
	output logic [DATA_W-1:0] rf_wdata,
	output logic [15:0] led
);

	logic grant_bld;
	logic grant_cpu;
	logic [4:0] led_addr;
	logic [4:0] led_data;

	// Builder always wins, a colliding CPU write is dropped
	assign grant_bld = bld_we;
	assign grant_cpu = cpu_we && !bld_we;

	assign rf_we = grant_bld || grant_cpu;
	assign rf_waddr = grant_bld ? bld_waddr : cpu_waddr;
	assign rf_wdata = grant_bld ? bld_wdata : cpu_wdata;

	// Last granted write, held for the LEDs
	always_ff @(posedge BTNC) begin
		if (!CPU_RESETN) begin
			led_addr <= '0;
			led_data <= '0;
		end else if (rf_we) begin
			led_addr <= rf_waddr;
			led_data <= rf_wdata[4:0];
		end
	end

	assign led = {done, 5'b0, led_data, led_addr};

	// On a collision the LEDs must end up showing the builder's write
	a_builder_wins: assert property (@(posedge BTNC) disable iff (!CPU_RESETN)
		(bld_we && cpu_we) |=> (led[4:0] == $past(bld_waddr))
			&& (led[9:5] == $past(bld_wdata[4:0])))
		else $error("CPU write granted over builder");

endmodule

`default_nettype wire

// File: regfile.sv
`default_nettype none
`timescale 1ns/1ns

module regfile import qgate_pkg::*; #(
	parameter int REG_COUNT = 32
) (
	input wire logic BTNC,
	input wire logic CPU_RESETN,
	input wire logic rf_we,
	input wire logic [REG_ADDR_W-1:0] rf_waddr,
	input wire logic [DATA_W-1:0] rf_wdata,
	input wire logic [REG_ADDR_W-1:0] cpu_raddr_a,
	input wire logic [REG_ADDR_W-1:0] cpu_raddr_b,
	output logic [DATA_W-1:0] rdata_a,
	output logic [DATA_W-1:0] rdata_b
);

	logic [DATA_W-1:0] regs [REG_COUNT];
	logic wr_ok;

	assign wr_ok = rf_we && (rf_waddr != '0); // r0 stays zero

	always_ff @(posedge BTNC) begin
		if (!CPU_RESETN) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_ok) begin
			regs[rf_waddr] <= rf_wdata;
		end
	end

	// Read ports see a write one edge after it lands
	assign rdata_a = regs[cpu_raddr_a];
	assign rdata_b = regs[cpu_raddr_b];

endmodule

`default_nettype wire

// File: qcircuit_top.sv
`default_nettype none
`timescale 1ns/1ns

module qcircuit_top import qgate_pkg::*; #(
	parameter int NUM_SLOTS = 5,
	parameter int REG_COUNT = 32
) (
	input wire logic BTNC,
	input wire logic CPU_RESETN,
	input wire logic btn_r,
	input wire logic btn_l,
	input wire logic btn_u,
	input wire logic btn_d,
	input wire logic btn_select,
	input wire logic cpu_we, // Processor write port
	input wire logic [REG_ADDR_W-1:0] cpu_waddr,
	input wire logic [DATA_W-1:0] cpu_wdata,
	input wire logic [REG_ADDR_W-1:0] cpu_raddr_a,
	input wire logic [REG_ADDR_W-1:0] cpu_raddr_b,
	output tile_t cursor,
	output logic [3:0] gate_count,
	output prob_t prob_a,
	output prob_t prob_b,
	output logic done,
	output logic [15:0] led,
	output logic [DATA_W-1:0] rdata_a,
	output logic [DATA_W-1:0] rdata_b
);

	logic bld_we;
	logic [REG_ADDR_W-1:0] bld_waddr;
	logic [DATA_W-1:0] bld_wdata;
	logic rf_we;
	logic [REG_ADDR_W-1:0] rf_waddr;
	logic [DATA_W-1:0] rf_wdata;

	cursor_nav nav0 (
		.BTNC(BTNC),
		.CPU_RESETN(CPU_RESETN),
		.btn_r(btn_r),
		.btn_l(btn_l),
		.btn_u(btn_u),
		.btn_d(btn_d),
		.cursor(cursor)
	);

	circuit_recorder #(.NUM_SLOTS(NUM_SLOTS)) rec0 (
		.BTNC(BTNC),
		.CPU_RESETN(CPU_RESETN),
		.btn_select(btn_select),
		.cursor(cursor),
		.gate_count(gate_count),
		.prob_a(prob_a),
		.prob_b(prob_b),
		.done(done),
		.bld_we(bld_we),
		.bld_waddr(bld_waddr),
		.bld_wdata(bld_wdata)
	);

	regfile_arbiter arb0 (
		.BTNC(BTNC),
		.CPU_RESETN(CPU_RESETN),
		.bld_we(bld_we),
		.bld_waddr(bld_waddr),
		.bld_wdata(bld_wdata),
		.cpu_we(cpu_we),
		.cpu_waddr(cpu_waddr),
		.cpu_wdata(cpu_wdata),
		.done(done),
		.rf_we(rf_we),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.led(led)
	);

	regfile #(.REG_COUNT(REG_COUNT)) rf0 (
		.BTNC(BTNC),
		.CPU_RESETN(CPU_RESETN),
		.rf_we(rf_we),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.cpu_raddr_a(cpu_raddr_a),
		.cpu_raddr_b(cpu_raddr_b),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b)
	);

endmodule

`default_nettype wire

// File: tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic check_tile(input string name, input tile_t got, input tile_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
	end
endtask

task automatic check_prob(input string name, input prob_t got, input prob_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("** Error at %0t ns: %s = %0d%%, expected %0d%%", $time, name, got, exp);
	end
endtask

// Also used for narrower outputs, zero-extended by the caller
task automatic check_word(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
	end
endtask

`endif

// File: tb_qcircuit.sv
`default_nettype none
`timescale 1ns/1ns

module tb_qcircuit import qgate_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int NUM_SLOTS = 5;
	// Cycle budget per test, reset included
	localparam int NAV_CYCLES = 30;
	localparam int PLACE_CYCLES = 40;
	localparam int OVERFLOW_CYCLES = 60;
	localparam int ARB_CYCLES = 40;
	localparam int RUN_CYCLES = 40;
	localparam int MARGIN_CYCLES = 100;
	localparam int WATCHDOG_CYCLES = NAV_CYCLES + PLACE_CYCLES + OVERFLOW_CYCLES
		+ ARB_CYCLES + RUN_CYCLES + MARGIN_CYCLES;

	logic BTNC;
	logic CPU_RESETN;
	logic btn_r;
	logic btn_l;
	logic btn_u;
	logic btn_d;
	logic btn_select;
	logic cpu_we;
	logic [REG_ADDR_W-1:0] cpu_waddr;
	logic [DATA_W-1:0] cpu_wdata;
	logic [REG_ADDR_W-1:0] cpu_raddr_a;
	logic [REG_ADDR_W-1:0] cpu_raddr_b;
	tile_t cursor;
	logic [3:0] gate_count;
	prob_t prob_a;
	prob_t prob_b;
	logic done;
	logic [15:0] led;
	logic [DATA_W-1:0] rdata_a;
	logic [DATA_W-1:0] rdata_b;

	`include "tb_checks.svh"

	integer seed = 32'h6291;
	tile_t exp_cursor; // Reference model state
	int exp_count;
	prob_t exp_prob_a;
	prob_t exp_prob_b;
	logic exp_done;

	qcircuit_top #(.NUM_SLOTS(NUM_SLOTS), .REG_COUNT(32)) dut0 (
		.BTNC(BTNC),
		.CPU_RESETN(CPU_RESETN),
		.btn_r(btn_r),
		.btn_l(btn_l),
		.btn_u(btn_u),
		.btn_d(btn_d),
		.btn_select(btn_select),
		.cpu_we(cpu_we),
		.cpu_waddr(cpu_waddr),
		.cpu_wdata(cpu_wdata),
		.cpu_raddr_a(cpu_raddr_a),
		.cpu_raddr_b(cpu_raddr_b),
		.cursor(cursor),
		.gate_count(gate_count),
		.prob_a(prob_a),
		.prob_b(prob_b),
		.done(done),
		.led(led),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b)
	);

	initial begin
		BTNC = 1'b0;
		forever #(CLK_PERIOD / 2) BTNC = ~BTNC;
	end

	// Cursor rules: rows 1-8, 9-16 and 17-18, each wrapping sideways
	function automatic tile_t next_tile(input tile_t cur, input byte dir);
		int t;
		int base;
		int n;
		t = int'(cur);
		n = t;
		base = (t <= 8) ? 1 : 9;
		if (dir == "R")
			n = (t >= 17) ? 35 - t : base + (t - base + 1) % 8;
		else if (dir == "L")
			n = (t >= 17) ? 35 - t : base + (t - base + 7) % 8;
		else if (dir == "U")
			n = (t == 17) ? 10 : (t == 18) ? 15 : (t >= 9) ? t - 8 : t;
		else if (dir == "D")
			n = (t <= 8) ? t + 8 : (t <= 12) ? 17 : (t <= 16) ? 18 : t;
		return tile_t'(n);
	endfunction

	function automatic int tile_row(input tile_t t);
		return (t <= 5'd8) ? 1 : (t <= 5'd16) ? 2 : 3;
	endfunction

	function automatic prob_t table_prob(input tile_t t);
		case (t)
			5'd1, 5'd2, 5'd5, 5'd6, 5'd9, 5'd10, 5'd13, 5'd14: return 9'd100;
			5'd3, 5'd7, 5'd11, 5'd15: return 9'd0;
			default: return 9'd50;
		endcase
	endfunction

	task automatic tick();
		@(posedge BTNC);
		#1;
	endtask

	task automatic apply_reset();
		CPU_RESETN = 1'b0;
		btn_r = 1'b0;
		btn_l = 1'b0;
		btn_u = 1'b0;
		btn_d = 1'b0;
		btn_select = 1'b0;
		cpu_we = 1'b0;
		cpu_waddr = '0;
		cpu_wdata = '0;
		cpu_raddr_a = '0;
		cpu_raddr_b = '0;
		repeat (4) tick();
		CPU_RESETN = 1'b1;
		exp_cursor = 5'd1;
		exp_count = 0;
		exp_prob_a = '0;
		exp_prob_b = '0;
		exp_done = 1'b0;
		check_tile("cursor", cursor, exp_cursor);
		check_word("gate_count", DATA_W'(gate_count), 32'd0);
		check_word("done", DATA_W'(done), 32'd0);
	endtask

	task automatic press(input byte dir);
		btn_r = (dir == "R");
		btn_l = (dir == "L");
		btn_u = (dir == "U");
		btn_d = (dir == "D");
		tick();
		{btn_r, btn_l, btn_u, btn_d} = 4'b0;
		exp_cursor = next_tile(exp_cursor, dir);
		check_tile("cursor", cursor, exp_cursor);
	endtask

	task automatic goto_tile(input tile_t target);
		while (exp_cursor != target) begin
			if (tile_row(target) < tile_row(exp_cursor))
				press("U");
			else if (tile_row(target) > tile_row(exp_cursor))
				press("D");
			else
				press("R");
		end
	endtask

	// One select strobe on the current tile, then compare with the model
	task automatic select_here();
		tile_t t;
		t = exp_cursor;
		btn_select = 1'b1;
		tick();
		btn_select = 1'b0;
		if (t == 5'd18) begin
			exp_count = 0;
			exp_prob_a = '0;
			exp_prob_b = '0;
		end else if (t == 5'd17) begin
			exp_done = 1'b1;
		end else if (!exp_done && exp_count < NUM_SLOTS) begin
			if (exp_count < 2 && ((t <= 5'd4) || (t >= 5'd9 && t <= 5'd12)))
				exp_prob_a = table_prob(t);
			else if (exp_count < 2)
				exp_prob_b = table_prob(t);
			exp_count++;
		end
		check_word("gate_count", DATA_W'(gate_count), DATA_W'(exp_count));
		check_prob("prob_a", prob_a, exp_prob_a);
		check_prob("prob_b", prob_b, exp_prob_b);
		check_word("done", DATA_W'(done), DATA_W'(exp_done));
	endtask

	task automatic place(input tile_t t);
		goto_tile(t);
		select_here();
	endtask

	task automatic expect_reg(input logic [REG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
		cpu_raddr_a = addr;
		cpu_raddr_b = addr;
		#1;
		check_word($sformatf("rdata_a[r%0d]", addr), rdata_a, exp);
		check_word($sformatf("rdata_b[r%0d]", addr), rdata_b, exp);
	endtask

	// Whole LED word, done flag on top
	task automatic check_led(input logic [4:0] addr, input logic [4:0] data);
		check_word("led", DATA_W'(led), DATA_W'({exp_done, 5'b0, data, addr}));
	endtask

	task automatic test_navigation();
		string walk;
		walk = "LRDLRDRRURRDLUDUUUDDDLD"; // Every wrap, row change and held move
		apply_reset();
		for (int i = 0; i < walk.len(); i++)
			press(walk[i]);
	endtask

	task automatic test_placement();
		apply_reset();
		place(5'd4); // Qubit a, 50
		place(5'd6); // Qubit b, 100
		place(5'd11); // Third gate leaves both probabilities alone
		tick();
		expect_reg(5'd0, 32'd0); // Slot 0 lands on r0
		expect_reg(5'd1, 32'd6);
		expect_reg(5'd2, 32'd11);
	endtask

	task automatic test_overflow_clear();
		apply_reset();
		place(5'd1);
		place(5'd16);
		place(5'd7);
		place(5'd10);
		place(5'd3);
		tick();
		check_led(5'd4, 5'd3);
		place(5'd8); // No free slot
		tick();
		check_led(5'd4, 5'd3);
		expect_reg(5'd4, 32'd3);
		place(5'd18);
	endtask

	task automatic test_arbitration();
		logic [DATA_W-1:0] cpu_data;
		apply_reset();
		place(5'd9);
		place(5'd14); // Builder write to r1 is pending now
		cpu_we = 1'b1;
		cpu_waddr = 5'd20;
		cpu_wdata = $random(seed);
		tick();
		cpu_we = 1'b0;
		expect_reg(5'd1, 32'd14);
		expect_reg(5'd20, 32'd0);
		check_led(5'd1, 5'd14);
		cpu_data = $random(seed);
		cpu_we = 1'b1;
		cpu_waddr = 5'd21;
		cpu_wdata = cpu_data;
		tick();
		cpu_we = 1'b0;
		expect_reg(5'd21, cpu_data);
		check_led(5'd21, cpu_data[4:0]);
	endtask

	task automatic test_run();
		apply_reset();
		place(5'd2);
		place(5'd17);
		tick();
		expect_reg(5'd6, 32'd999);
		check_word("led[15]", DATA_W'(led[15]), 32'd1);
		check_led(5'd6, 5'd7); // Low bits of 999
		place(5'd5); // Ignored once done
		tick();
		expect_reg(5'd1, 32'd0);
		check_led(5'd6, 5'd7);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		test_navigation();
		test_placement();
		test_overflow_clear();
		test_arbitration();
		test_run();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
qgate_pkg.sv
cursor_nav.sv
circuit_recorder.sv
regfile_arbiter.sv
regfile.sv
qcircuit_top.sv
tb_qcircuit.sv

// File: Makefile
TOP = tb_qcircuit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
